/* aes_entropy.f */
verilog/edn_if_pkg.sv
verilog/aes_prng_pkg.sv
verilog/aes_prng.sv
verilog/aes_edn_arb.sv
verilog/aes_entropy_top.sv
dv/tb_clk_gen.sv
dv/aes_entropy_tb.sv

/* dv/aes_entropy_tb.sv */
// Testbench for the AES entropy block with a random EDN responder.
// Inputs change on the falling edge, models update on the rising edge,
// and DUT outputs are compared with the models on the next falling edge.
`timescale 1ns/1ps

module aes_entropy_tb
  import edn_if_pkg::*;
  import aes_prng_pkg::*;
();

  localparam int MaxCycles = 3000;
  localparam int WaitLimit = 100;

  logic         clk_i;
  logic         rst_ni;
  logic         escalate_i;
  logic         clear_reseed_i;
  logic         clear_step_i;
  logic         mask_reseed_i;
  logic         mask_step_i;
  logic         edn_ack_i;
  edn_word_t    edn_data_i;
  logic         clear_valid_o;
  logic         mask_valid_o;
  logic         edn_req_o;
  clear_state_t clear_data_o;
  mask_state_t  mask_data_o;

  // Generator and arbiter models
  clear_state_t m_clear_state;
  clear_state_t m_clear_seed;
  int           m_clear_cnt;
  logic         m_clear_pend;
  mask_state_t  m_mask_state;
  int           m_mask_steps;
  logic         m_mask_pend;
  logic         m_hold;
  edn_word_t    word_log[$];

  // EDN responder
  integer seed;
  int     wait_cnt;
  logic   armed;
  logic   pause_edn;
  logic   zero_words;

  int errors;
  int checks;
  int tests_failed;
  int test_errors;
  int cycles;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  aes_entropy_top aes_entropy_top_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .escalate_i     ( escalate_i     ),
    .clear_reseed_i ( clear_reseed_i ),
    .clear_step_i   ( clear_step_i   ),
    .clear_valid_o  ( clear_valid_o  ),
    .clear_data_o   ( clear_data_o   ),
    .mask_reseed_i  ( mask_reseed_i  ),
    .mask_step_i    ( mask_step_i    ),
    .mask_valid_o   ( mask_valid_o   ),
    .mask_data_o    ( mask_data_o    ),
    .edn_req_o      ( edn_req_o      ),
    .edn_ack_i      ( edn_ack_i      ),
    .edn_data_i     ( edn_data_i     )
  );

  //////////////////////////////////////////////////
  // Models
  //////////////////////////////////////////////////

  // Right-shifting Galois LFSR step
  function automatic clear_state_t clear_lfsr(input clear_state_t s);
    return (s >> 1) ^ (s[0] ? ClearPoly : 64'd0);
  endfunction

  function automatic mask_state_t mask_lfsr(input mask_state_t s);
    return (s >> 1) ^ (s[0] ? MaskPoly : 32'd0);
  endfunction

  task automatic update_models();
    logic clr_ack;
    logic msk_ack;
    logic msk_acc;
    logic msk_start;
    clr_ack = edn_ack_i && m_clear_pend;
    msk_ack = edn_ack_i && !m_clear_pend && m_mask_pend;
    if (edn_ack_i) begin
      word_log.push_back(edn_data_i);
    end
    m_hold = (m_clear_pend || m_mask_pend || m_hold) && !edn_ack_i;
    // Clearing generator
    if (!m_clear_pend && clear_step_i) begin
      m_clear_state = clear_lfsr(m_clear_state);
    end
    if (escalate_i) begin
      m_clear_pend = 1'b0;
      m_clear_cnt  = 0;
    end else if (!m_clear_pend && clear_reseed_i) begin
      m_clear_pend = 1'b1;
      m_clear_cnt  = 0;
    end else if (clr_ack) begin
      m_clear_seed[m_clear_cnt*EdnWidth +: EdnWidth] = edn_data_i;
      if (m_clear_cnt == 1) begin
        m_clear_state = (m_clear_seed == '0) ? ClearSeedDefault : m_clear_seed;
        m_clear_pend  = 1'b0;
        m_clear_cnt   = 0;
      end else begin
        m_clear_cnt++;
      end
    end
    // Masking generator, the step that hits the interval still applies
    msk_acc   = mask_step_i && !m_mask_pend;
    msk_start = !m_mask_pend &&
                (mask_reseed_i || (msk_acc && m_mask_steps == MaskReseedSteps - 1));
    if (msk_acc) begin
      m_mask_state = mask_lfsr(m_mask_state);
    end
    if (msk_start) begin
      m_mask_steps = 0;
    end else if (msk_acc) begin
      m_mask_steps++;
    end
    if (escalate_i) begin
      m_mask_pend = 1'b0;
    end else if (msk_start) begin
      m_mask_pend = 1'b1;
    end else if (msk_ack) begin
      m_mask_state = (edn_data_i == '0) ? MaskSeedDefault : edn_data_i;
      m_mask_pend  = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Checking and EDN responder
  //////////////////////////////////////////////////

  task automatic log_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  task automatic check_outputs();
    checks++;
    if (clear_valid_o !== ~m_clear_pend) log_error("clear_valid_o differs from model");
    if (mask_valid_o !== ~m_mask_pend) log_error("mask_valid_o differs from model");
    if (clear_data_o !== m_clear_state) begin
      log_error($sformatf("clear_data_o %h, model %h", clear_data_o, m_clear_state));
    end
    if (mask_data_o !== m_mask_state) begin
      log_error($sformatf("mask_data_o %h, model %h", mask_data_o, m_mask_state));
    end
    if (edn_req_o !== (m_clear_pend | m_mask_pend | m_hold)) begin
      log_error("edn_req_o differs from model");
    end
  endtask

  // Random delay of 0 to 7 cycles, never two acks in a row
  task automatic respond_edn();
    if (edn_ack_i) begin
      edn_ack_i = 1'b0;
    end else if (edn_req_o && !pause_edn) begin
      if (!armed) begin
        armed    = 1'b1;
        wait_cnt = $random(seed) & 7;
      end
      if (wait_cnt == 0) begin
        edn_ack_i  = 1'b1;
        edn_data_i = zero_words ? '0 : edn_word_t'($random(seed));
        armed      = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    update_models();
    @(negedge clk_i);
    check_outputs();
    respond_edn();
  endtask

  task automatic wait_reseed_done(input logic is_clear);
    int n;
    n = 0;
    while (is_clear ? !clear_valid_o : !mask_valid_o) begin
      if (n == WaitLimit) begin
        report_problem("generator reseed did not complete in time");
        return;
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!(clear_valid_o && mask_valid_o && !edn_req_o)) begin
      if (n == WaitLimit) begin
        report_problem("entropy block did not return to idle");
        return;
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_errors) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    clear_state_t exp_clear;
    mask_state_t  exp_mask;
    clear_state_t old_clear;
    mask_state_t  old_mask;
    int           n;
    seed           = 32'h5307812e;
    escalate_i     = 1'b0;
    clear_reseed_i = 1'b0;
    clear_step_i   = 1'b0;
    mask_reseed_i  = 1'b0;
    mask_step_i    = 1'b0;
    edn_ack_i      = 1'b0;
    edn_data_i     = '0;
    m_clear_state  = ClearSeedDefault;
    m_clear_seed   = '0;
    m_clear_cnt    = 0;
    m_clear_pend   = 1'b0;
    m_mask_state   = MaskSeedDefault;
    m_mask_steps   = 0;
    m_mask_pend    = 1'b0;
    m_hold         = 1'b0;
    armed          = 1'b0;
    wait_cnt       = 0;
    pause_edn      = 1'b0;
    zero_words     = 1'b0;
    errors         = 0;
    checks         = 0;
    tests_failed   = 0;
    test_errors    = 0;
    cycles         = 0;
    wait (rst_ni === 1'b1);

    checks++;
    if (edn_req_o !== 1'b0) log_error("edn_req_o high after reset");
    if (clear_valid_o !== 1'b1) log_error("clear_valid_o low after reset");
    if (mask_valid_o !== 1'b1) log_error("mask_valid_o low after reset");
    if (clear_data_o !== ClearSeedDefault) log_error("clear_data_o not the default seed");
    if (mask_data_o !== MaskSeedDefault) log_error("mask_data_o not the default seed");
    finish_test(1, "reset values");

    // Masking generator may reseed by itself along the way
    for (int i = 0; i < 200; i++) begin
      clear_step_i = $random(seed) & 1;
      mask_step_i  = $random(seed) & 1;
      next_cycle();
    end
    clear_step_i = 1'b0;
    mask_step_i  = 1'b0;
    wait_idle();
    finish_test(2, "random stepping");

    // Second round forces all-zero words to hit the default seed
    for (int round = 0; round < 2; round++) begin
      zero_words = (round == 1);
      word_log.delete();
      clear_reseed_i = 1'b1;
      next_cycle();
      clear_reseed_i = 1'b0;
      if (clear_valid_o !== 1'b0) log_error("clear_valid_o high after reseed request");
      wait_reseed_done(1'b1);
      if (word_log.size() != 2) begin
        log_error($sformatf("clearing reseed took %0d words", word_log.size()));
      end else begin
        exp_clear = {word_log[1], word_log[0]};
        if (exp_clear == '0) exp_clear = ClearSeedDefault;
        if (clear_data_o !== exp_clear) log_error("clear_data_o is not the collected seed");
      end
      zero_words   = 1'b0;
      clear_step_i = 1'b1;
      repeat (20) next_cycle();
      clear_step_i = 1'b0;
    end
    finish_test(3, "clearing reseed");

    word_log.delete();
    clear_reseed_i = 1'b1;
    mask_reseed_i  = 1'b1;
    next_cycle();
    clear_reseed_i = 1'b0;
    mask_reseed_i  = 1'b0;
    n = 0;
    while (!(clear_valid_o && mask_valid_o) && n < WaitLimit) begin
      if (mask_valid_o && !clear_valid_o) log_error("masking served before clearing");
      next_cycle();
      n++;
    end
    if (word_log.size() != 3) begin
      report_problem("joint reseed did not take exactly three words");
    end else begin
      exp_clear = {word_log[1], word_log[0]};
      if (exp_clear == '0) exp_clear = ClearSeedDefault;
      exp_mask = (word_log[2] == '0) ? MaskSeedDefault : word_log[2];
      if (clear_data_o !== exp_clear) log_error("clear_data_o not the first two words");
      if (mask_data_o !== exp_mask) log_error("mask_data_o not the third word");
    end
    wait_idle();
    finish_test(4, "joint reseed priority");

    // The joint reseed cleared the step count
    clear_step_i = 1'b1;
    mask_step_i  = 1'b1;
    for (int i = 1; i <= MaskReseedSteps; i++) begin
      next_cycle();
      if (i < MaskReseedSteps && mask_valid_o !== 1'b1) begin
        log_error($sformatf("masking reseed started early at step %0d", i));
      end
    end
    if (mask_valid_o !== 1'b0) log_error("no automatic reseed after the step interval");
    if (clear_valid_o !== 1'b1) log_error("clearing generator stopped during mask reseed");
    word_log.delete();
    wait_reseed_done(1'b0);
    clear_step_i = 1'b0;
    mask_step_i  = 1'b0;
    if (word_log.size() != 1) begin
      report_problem("automatic reseed did not take exactly one word");
    end else begin
      exp_mask = (word_log[0] == '0) ? MaskSeedDefault : word_log[0];
      if (mask_data_o !== exp_mask) log_error("mask_data_o not the reseed word");
    end
    wait_idle();
    finish_test(5, "automatic mask reseed");

    pause_edn      = 1'b1;
    clear_reseed_i = 1'b1;
    mask_reseed_i  = 1'b1;
    next_cycle();
    clear_reseed_i = 1'b0;
    mask_reseed_i  = 1'b0;
    next_cycle();
    old_clear  = m_clear_state;
    old_mask   = m_mask_state;
    escalate_i = 1'b1;
    next_cycle();
    escalate_i = 1'b0;
    if (clear_valid_o !== 1'b1 || mask_valid_o !== 1'b1) log_error("valid low after escalation");
    if (clear_data_o !== old_clear) log_error("clear_data_o changed on escalation");
    if (mask_data_o !== old_mask) log_error("mask_data_o changed on escalation");
    repeat (3) begin
      next_cycle();
      if (edn_req_o !== 1'b1) log_error("edn_req_o dropped before acknowledge");
    end
    pause_edn = 1'b0;
    word_log.delete();
    n = 0;
    while (word_log.size() == 0 && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    if (word_log.size() == 0) report_problem("held EDN request was never acknowledged");
    if (clear_data_o !== old_clear) log_error("absorbed acknowledge changed clear_data_o");
    if (mask_data_o !== old_mask) log_error("absorbed acknowledge changed mask_data_o");
    if (edn_req_o !== 1'b0) log_error("edn_req_o still high after acknowledge");
    finish_test(6, "escalation abort");

    $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Generous bound over the summed test lengths
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      if (cycles >= MaxCycles) begin
        $display("Timeout: run did not finish within %0d cycles", MaxCycles);
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
  end

endmodule

/* dv/tb_clk_gen.sv */
// Free-running testbench clock with an active-low reset at start-up.
// Reset is released on a falling edge, away from the sampling edge.
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* verilog/aes_entropy_top.sv */
// Entropy block of the AES engine: clearing and masking generators on one EDN port.
// Arbitration adds no cycles to the generator reseed latency.
// escalate_i aborts pending reseeds in both generators.
`timescale 1ns/1ps

module aes_entropy_top
  import edn_if_pkg::*;
  import aes_prng_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         escalate_i,

  // Clearing generator
  input  logic         clear_reseed_i,
  input  logic         clear_step_i,
  output logic         clear_valid_o,
  output clear_state_t clear_data_o,

  // Masking generator
  input  logic         mask_reseed_i,
  input  logic         mask_step_i,
  output logic         mask_valid_o,
  output mask_state_t  mask_data_o,

  // EDN port
  output logic         edn_req_o,
  input  logic         edn_ack_i,
  input  edn_word_t    edn_data_i
);

  logic clear_req;
  logic clear_ack;
  logic mask_req;
  logic mask_ack;

  //////////////////////////////////////////////////
  // Generators
  //////////////////////////////////////////////////

  // Software-reseeded only
  aes_prng #(
    .state_t         ( clear_state_t    ),
    .Poly            ( ClearPoly        ),
    .DefaultSeed     ( ClearSeedDefault ),
    .AutoReseedSteps ( 0                )
  ) u_prng_clear (
    .clk_i     ( clk_i          ),
    .rst_ni    ( rst_ni         ),
    .reseed_i  ( clear_reseed_i ),
    .step_i    ( clear_step_i   ),
    .abort_i   ( escalate_i     ),
    .req_o     ( clear_req      ),
    .ack_i     ( clear_ack      ),
    .entropy_i ( edn_data_i     ),
    .valid_o   ( clear_valid_o  ),
    .data_o    ( clear_data_o   )
  );

  aes_prng #(
    .state_t         ( mask_state_t    ),
    .Poly            ( MaskPoly        ),
    .DefaultSeed     ( MaskSeedDefault ),
    .AutoReseedSteps ( MaskReseedSteps )
  ) u_prng_mask (
    .clk_i     ( clk_i         ),
    .rst_ni    ( rst_ni        ),
    .reseed_i  ( mask_reseed_i ),
    .step_i    ( mask_step_i   ),
    .abort_i   ( escalate_i    ),
    .req_o     ( mask_req      ),
    .ack_i     ( mask_ack      ),
    .entropy_i ( edn_data_i    ),
    .valid_o   ( mask_valid_o  ),
    .data_o    ( mask_data_o   )
  );

  //////////////////////////////////////////////////
  // EDN arbitration
  //////////////////////////////////////////////////

  aes_edn_arb u_edn_arb (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_req_i ( clear_req ),
    .clear_ack_o ( clear_ack ),
    .mask_req_i  ( mask_req  ),
    .mask_ack_o  ( mask_ack  ),
    .edn_req_o   ( edn_req_o ),
    .edn_ack_i   ( edn_ack_i )
  );

endmodule

/* verilog/aes_edn_arb.sv */
// Fixed-priority arbiter sharing one EDN port between two requesters.
// The clearing request always wins; the acknowledge goes to one requester only.
// A request dropped before its acknowledge is held on the EDN port,
// and the late acknowledge is then absorbed.
`timescale 1ns/1ps

module aes_edn_arb (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_req_i,
  output logic clear_ack_o,
  input  logic mask_req_i,
  output logic mask_ack_o,
  output logic edn_req_o,
  input  logic edn_ack_i
);

  logic req_any;
  logic hold_q, hold_d;

  //////////////////////////////////////////////////
  // Request merge and acknowledge steering
  //////////////////////////////////////////////////

  assign req_any = clear_req_i | mask_req_i;

  // Clearing generator has priority
  assign clear_ack_o = clear_req_i & edn_ack_i;
  assign mask_ack_o  = ~clear_req_i & mask_req_i & edn_ack_i;

  //////////////////////////////////////////////////
  // Request hold
  //////////////////////////////////////////////////

  // Keeps the EDN handshake complete when a generator aborts mid-request
  assign edn_req_o = req_any | hold_q;
  assign hold_d    = edn_req_o & ~edn_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= hold_d;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // EDN only acknowledges an outstanding request
  EdnAckOnReq_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_ack_i |-> edn_req_o);

  // Acknowledge is a single-cycle pulse
  EdnAckPulse_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_ack_i |=> !edn_ack_i);

endmodule

/* verilog/aes_prng.sv */
// Reseedable Galois LFSR with built-in upsizing of EDN words to the state width.
// The state width must be a whole multiple of EdnWidth.
// Steps are ignored while a reseed is pending (valid_o low).
// An all-zero collected seed is replaced by DefaultSeed.
`timescale 1ns/1ps

module aes_prng
  import edn_if_pkg::*;
  import aes_prng_pkg::*;
#(
  parameter type    state_t         = mask_state_t,
  parameter state_t Poly            = MaskPoly,
  parameter state_t DefaultSeed     = MaskSeedDefault,
  parameter int     AutoReseedSteps = 0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      reseed_i,
  input  logic      step_i,
  input  logic      abort_i,
  output logic      req_o,
  input  logic      ack_i,
  input  edn_word_t entropy_i,
  output logic      valid_o,
  output state_t    data_o
);

  localparam int StateWidth = $bits(state_t);
  localparam int NumWords   = StateWidth / EdnWidth;
  localparam int CntWidth   = (NumWords > 1) ? $clog2(NumWords) : 1;

  state_t              state_q, state_d;
  state_t              seed_q, seed_d;
  state_t              lfsr_next;
  logic [CntWidth-1:0] word_cnt_q, word_cnt_d;
  logic                pend_q, pend_d;
  logic                step_acc;
  logic                auto_reseed;
  logic                reseed_start;
  logic                word_ack;
  logic                last_word;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  assign step_acc     = step_i & ~pend_q;
  assign reseed_start = ~pend_q & (reseed_i | auto_reseed);
  // Abort wins over a word arriving in the same cycle
  assign word_ack     = ack_i & pend_q & ~abort_i;
  assign last_word    = (word_cnt_q == CntWidth'(NumWords - 1));

  always_comb begin
    pend_d     = pend_q;
    word_cnt_d = word_cnt_q;
    if (abort_i) begin
      pend_d     = 1'b0;
      word_cnt_d = '0;
    end else if (reseed_start) begin
      pend_d     = 1'b1;
      word_cnt_d = '0;
    end else if (word_ack) begin
      if (last_word) begin
        pend_d     = 1'b0;
        word_cnt_d = '0;
      end else begin
        word_cnt_d = word_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q     <= 1'b0;
      word_cnt_q <= '0;
    end else begin
      pend_q     <= pend_d;
      word_cnt_q <= word_cnt_d;
    end
  end

  // Automatic reseed after a fixed number of accepted steps
  if (AutoReseedSteps > 0) begin : gen_auto_reseed
    localparam int StepCntWidth = $clog2(AutoReseedSteps + 1);
    logic [StepCntWidth-1:0] step_cnt_q;

    assign auto_reseed = step_acc & (step_cnt_q == StepCntWidth'(AutoReseedSteps - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        step_cnt_q <= '0;
      end else if (reseed_start) begin
        step_cnt_q <= '0;
      end else if (step_acc) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
    end
  end else begin : gen_no_auto_reseed
    assign auto_reseed = 1'b0;
  end

  //////////////////////////////////////////////////
  // Seed collection and LFSR
  //////////////////////////////////////////////////

  // Current word merged in, so the last word loads in its own cycle
  always_comb begin
    seed_d = seed_q;
    for (int i = 0; i < NumWords; i++) begin
      if (word_cnt_q == CntWidth'(i)) begin
        seed_d[i*EdnWidth +: EdnWidth] = entropy_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_ack) begin
      seed_q <= seed_d;
    end
  end

  assign lfsr_next = (state_q >> 1) ^ (state_q[0] ? Poly : '0);

  always_comb begin
    state_d = state_q;
    if (word_ack && last_word) begin
      state_d = (seed_d == '0) ? DefaultSeed : seed_d;
    end else if (step_acc) begin
      state_d = lfsr_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DefaultSeed;
    end else begin
      state_q <= state_d;
    end
  end

  assign req_o   = pend_q;
  assign valid_o = ~pend_q;
  assign data_o  = state_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Zero fallback and the Galois step must keep the LFSR out of the lock-up state
  StateNonZero_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0);

  // Arbiter must only route an acknowledge to a requesting generator
  AckOnlyOnReq_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |-> req_o);

endmodule

/* verilog/aes_prng_pkg.sv */
// Types and constants for the two reseedable generators.
// State widths must be whole multiples of the EDN word width.
// Default seeds are nonzero, since an all-zero LFSR state never leaves zero.

package aes_prng_pkg;

  //////////////////////////////////////////////////
  // State types
  //////////////////////////////////////////////////

  // Clearing generator, 64-bit words for wiping data paths
  typedef logic [63:0] clear_state_t;

  // Masking generator, 32-bit words for share masks
  typedef logic [31:0] mask_state_t;

  //////////////////////////////////////////////////
  // Feedback taps
  //////////////////////////////////////////////////

  // Right-shifting Galois form, taps 64, 63, 61, 60
  localparam clear_state_t ClearPoly = 64'hD800000000000000;

  // Right-shifting Galois form, taps 32, 22, 2, 1
  localparam mask_state_t MaskPoly = 32'h80200003;

  //////////////////////////////////////////////////
  // Seeds and reseed interval
  //////////////////////////////////////////////////

  // Loaded at reset and whenever a collected seed is all zero
  localparam clear_state_t ClearSeedDefault = 64'h3C9A51E70B84D26F;
  localparam mask_state_t  MaskSeedDefault  = 32'h6D2B94C1;

  // Accepted steps before the masking generator reseeds by itself
  localparam int MaskReseedSteps = 64;

endpackage

/* verilog/edn_if_pkg.sv */
// Shared entropy network (EDN) port definitions.
// The EDN port runs on the core clock; there is no clock-domain crossing.
// Handshake is a level request with a one-cycle acknowledge pulse,
// and the data word is valid in the acknowledge cycle only.

package edn_if_pkg;

  //////////////////////////////////////////////////
  // Entropy word
  //////////////////////////////////////////////////

  // Width of one word delivered per acknowledge
  localparam int EdnWidth = 32;

  // One entropy word as seen on the EDN bus
  typedef logic [EdnWidth-1:0] edn_word_t;

  // Consumers that need more than one word collect them internally,
  // lowest word first

endpackage
